// File: verilog/recorder_pkg.sv
`default_nettype none

package recorder_pkg;

	//////////////////////////////////////////////////////////////////////
	// audio data
	//////////////////////////////////////////////////////////////////////

	localparam int SAMPLE_W = 16;

	// one signed pcm sample
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// message slots, all the same length
	localparam int NUM_SLOTS = 5;

	// volume level limits
	localparam logic [3:0] VOL_MIN   = 4'd1;
	localparam logic [3:0] VOL_MAX   = 4'd15;
	localparam logic [3:0] VOL_RESET = 4'd8;

	//////////////////////////////////////////////////////////////////////
	// host port bus
	//////////////////////////////////////////////////////////////////////

	// operating mode, value written to the mode port
	typedef enum logic [7:0] {
		MODE_MAIN   = 8'h00,
		MODE_PLAY   = 8'h01,
		MODE_RECORD = 8'h02,
		MODE_DELONE = 8'h03,
		MODE_DELALL = 8'h04,
		MODE_VOL    = 8'h05
	} mode_e;

	// port numbers, writes and reads share one id space
	typedef enum logic [7:0] {
		PORT_VOLUME    = 8'h04,
		PORT_RECORD    = 8'h05,
		PORT_VOL_LEVEL = 8'h06,
		PORT_MODE      = 8'h0B,
		PORT_SLOT      = 8'h0C,
		PORT_STATUS    = 8'h0F
	} port_e;

	// transfer sequencer states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_PLAY_REQ,
		ST_PLAY_WAIT,
		ST_PLAY_NEXT,
		ST_REC_WAIT,
		ST_REC_WRITE,
		ST_ERASE_WRITE,
		ST_ERASE_NEXT
	} state_e;

endpackage

`default_nettype wire

// File: verilog/port_regs.sv
`default_nettype none

module port_regs (
	input  wire                 clk2,
	input  wire                 pb_reset,
	input  wire  [7:0]          port_id,
	input  wire  [7:0]          out_port,
	input  wire                 write_strobe,
	input  wire                 read_strobe,
	input  wire                 rec_wrote,
	input  wire                 erase_done_pulse,
	input  wire                 erase_all,
	input  wire  [2:0]          cur_slot,
	output logic [7:0]          in_port,
	output recorder_pkg::mode_e mode,
	output logic [2:0]          slot,
	output logic                record_arm,
	output logic [3:0]          volume,
	output logic                cmd_start,
	output logic                cmd_abort
);
	import recorder_pkg::*;

	logic                 wr_mode;
	logic                 wr_slot;
	logic                 wr_volume;
	logic                 wr_record;
	logic                 slot_mode;
	logic [NUM_SLOTS-1:0] occupied;
	logic                 erase_done;
	logic [7:0]           rd_data;

	// write port decode
	assign wr_mode   = write_strobe && (port_id == PORT_MODE);
	assign wr_slot   = write_strobe && (port_id == PORT_SLOT);
	assign wr_volume = write_strobe && (port_id == PORT_VOLUME);
	assign wr_record = write_strobe && (port_id == PORT_RECORD);

	// modes that act on a single slot
	assign slot_mode = (mode == MODE_PLAY) || (mode == MODE_RECORD) || (mode == MODE_DELONE);

	//////////////////////////////////////////////////////////////////////
	// control registers and command pulses
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			mode       <= MODE_MAIN;
			slot       <= 3'd0;
			record_arm <= 1'b0;
			volume     <= VOL_RESET;
			cmd_start  <= 1'b0;
			cmd_abort  <= 1'b0;
		end else begin
			// pulses last one cycle
			cmd_start <= 1'b0;
			cmd_abort <= 1'b0;
			if (wr_mode) begin
				// any mode change stops the running transfer
				cmd_abort  <= 1'b1;
				record_arm <= 1'b0;
				if (out_port <= MODE_VOL) begin
					mode <= mode_e'(out_port);
				end
				// erase all needs no slot, start right away
				if (out_port == MODE_DELALL) begin
					cmd_start <= 1'b1;
				end
			end
			// slot pick, only 0..4
			if (wr_slot && slot_mode && (out_port < NUM_SLOTS)) begin
				slot      <= out_port[2:0];
				cmd_start <= 1'b1;
			end
			// 1 steps up, 2 steps down, saturating
			if (wr_volume && (mode == MODE_VOL)) begin
				if ((out_port == 8'd1) && (volume < VOL_MAX)) begin
					volume <= volume + 4'd1;
				end else if ((out_port == 8'd2) && (volume > VOL_MIN)) begin
					volume <= volume - 4'd1;
				end
			end
			// arm bit only counts in record mode
			if (wr_record && (mode == MODE_RECORD)) begin
				record_arm <= out_port[0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// slot occupancy and erase status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			occupied   <= '0;
			erase_done <= 1'b0;
		end else begin
			if (cmd_start) begin
				erase_done <= 1'b0;
			end
			// any word written marks the slot as holding a message
			if (rec_wrote) begin
				occupied[cur_slot] <= 1'b1;
			end
			if (erase_done_pulse) begin
				erase_done <= 1'b1;
				if (erase_all) begin
					occupied <= '0;
				end else begin
					occupied[cur_slot] <= 1'b0;
				end
			end
		end
	end

	// read mux, unknown ports give zero
	always_comb begin
		case (port_id)
			PORT_STATUS:    rd_data = {2'b00, occupied, erase_done};
			PORT_VOL_LEVEL: rd_data = {4'h0, volume};
			default:        rd_data = 8'h00;
		endcase
	end

	// in_port captured on the read cycle, held after
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			in_port <= 8'h00;
		end else if (read_strobe) begin
			in_port <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/recorder_fsm.sv
`default_nettype none

module recorder_fsm (
	input  wire                        clk2,
	input  wire                        pb_reset,
	input  wire  recorder_pkg::mode_e  mode,
	input  wire                        cmd_start,
	input  wire                        cmd_abort,
	input  wire                        record_arm,
	input  wire                        sample_in_valid,
	input  wire                        mem_ready,
	input  wire                        mem_rdata_valid,
	input  wire                        addr_last,
	output recorder_pkg::state_e       state,
	output logic                       addr_load,
	output logic                       addr_load_all,
	output logic                       addr_step,
	output logic                       mem_read_req,
	output logic                       mem_write,
	output logic                       rd_capture,
	output logic                       wr_zero,
	output logic                       audio_out_valid,
	output logic                       rec_wrote,
	output logic                       erase_done_pulse,
	output logic                       erase_all
);
	import recorder_pkg::*;

	state_e state_nxt;
	logic   arm_seen;
	logic   abort_pend;

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			state      <= ST_IDLE;
			erase_all  <= 1'b0;
			arm_seen   <= 1'b0;
			abort_pend <= 1'b0;
		end else begin
			state <= state_nxt;
			// kind of erase, held until the next start
			if ((state == ST_IDLE) && cmd_start) begin
				erase_all <= (mode == MODE_DELALL);
			end
			// only a falling arm ends a recording
			if (state == ST_IDLE) begin
				arm_seen <= 1'b0;
			end else if (record_arm) begin
				arm_seen <= 1'b1;
			end
			// abort during a read is held until the data returns
			if (state != ST_PLAY_WAIT) begin
				abort_pend <= 1'b0;
			end else if (cmd_abort) begin
				abort_pend <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and per-word strobes
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt        = state;
		addr_load        = 1'b0;
		addr_load_all    = 1'b0;
		addr_step        = 1'b0;
		mem_read_req     = 1'b0;
		mem_write        = 1'b0;
		rd_capture       = 1'b0;
		wr_zero          = 1'b0;
		audio_out_valid  = 1'b0;
		rec_wrote        = 1'b0;
		erase_done_pulse = 1'b0;
		case (state)
			ST_IDLE: begin
				if (cmd_start) begin
					case (mode)
						MODE_PLAY: begin
							addr_load = 1'b1;
							state_nxt = ST_PLAY_REQ;
						end
						MODE_RECORD: begin
							addr_load = 1'b1;
							state_nxt = ST_REC_WAIT;
						end
						MODE_DELONE: begin
							addr_load = 1'b1;
							state_nxt = ST_ERASE_WRITE;
						end
						MODE_DELALL: begin
							addr_load_all = 1'b1;
							state_nxt     = ST_ERASE_WRITE;
						end
						default: begin
							state_nxt = ST_IDLE;
						end
					endcase
				end
			end
			// playback, one read per word
			ST_PLAY_REQ: begin
				if (cmd_abort) begin
					state_nxt = ST_IDLE;
				end else if (mem_ready) begin
					mem_read_req = 1'b1;
					state_nxt    = ST_PLAY_WAIT;
				end
			end
			ST_PLAY_WAIT: begin
				if (mem_rdata_valid) begin
					rd_capture = 1'b1;
					if (cmd_abort || abort_pend) begin
						state_nxt = ST_IDLE;
					end else begin
						state_nxt = ST_PLAY_NEXT;
					end
				end
			end
			ST_PLAY_NEXT: begin
				// scaled sample is on audio_out now
				audio_out_valid = 1'b1;
				if (cmd_abort || addr_last) begin
					state_nxt = ST_IDLE;
				end else begin
					addr_step = 1'b1;
					state_nxt = ST_PLAY_REQ;
				end
			end
			// recording, sample register loads as the sample arrives
			ST_REC_WAIT: begin
				if (cmd_abort || (arm_seen && !record_arm)) begin
					state_nxt = ST_IDLE;
				end else if (sample_in_valid && record_arm) begin
					state_nxt = ST_REC_WRITE;
				end
			end
			ST_REC_WRITE: begin
				if (cmd_abort) begin
					state_nxt = ST_IDLE;
				end else if (mem_ready) begin
					mem_write = 1'b1;
					rec_wrote = 1'b1;
					if (addr_last) begin
						state_nxt = ST_IDLE;
					end else begin
						addr_step = 1'b1;
						state_nxt = ST_REC_WAIT;
					end
				end
			end
			// erase, one zero word every two cycles
			ST_ERASE_WRITE: begin
				wr_zero = 1'b1;
				if (cmd_abort) begin
					state_nxt = ST_IDLE;
				end else if (mem_ready) begin
					mem_write = 1'b1;
					state_nxt = ST_ERASE_NEXT;
				end
			end
			ST_ERASE_NEXT: begin
				wr_zero = 1'b1;
				if (cmd_abort) begin
					state_nxt = ST_IDLE;
				end else if (addr_last) begin
					erase_done_pulse = 1'b1;
					state_nxt        = ST_IDLE;
				end else begin
					addr_step = 1'b1;
					state_nxt = ST_ERASE_WRITE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/address_counter.sv
`default_nettype none

module address_counter #(
	parameter int ADDR_W     = 12,
	parameter int SLOT_WORDS = 16
) (
	input  wire               clk2,
	input  wire               pb_reset,
	input  wire  [2:0]        slot,
	input  wire               addr_load,
	input  wire               addr_load_all,
	input  wire               addr_step,
	output logic [ADDR_W-1:0] mem_addr,
	output logic              addr_last
);
	import recorder_pkg::*;

	// words per slot and last word of the whole message area
	localparam logic [ADDR_W-1:0] WORDS_A = ADDR_W'(SLOT_WORDS);
	localparam logic [ADDR_W-1:0] TOP_A   = ADDR_W'(NUM_SLOTS * SLOT_WORDS - 1);

	logic [ADDR_W-1:0] slot_base;
	logic [ADDR_W-1:0] slot_top;
	logic [ADDR_W-1:0] last_addr;

	// slot range, base = slot * words
	assign slot_base = ADDR_W'(slot) * WORDS_A;
	assign slot_top  = slot_base + WORDS_A - ADDR_W'(1);

	//////////////////////////////////////////////////////////////////////
	// running address
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			mem_addr  <= '0;
			last_addr <= '0;
		end else if (addr_load_all) begin
			// whole memory, from word 0
			mem_addr  <= '0;
			last_addr <= TOP_A;
		end else if (addr_load) begin
			mem_addr  <= slot_base;
			last_addr <= slot_top;
		end else if (addr_step) begin
			mem_addr <= mem_addr + ADDR_W'(1);
		end
	end

	// high while on the final word of the range
	assign addr_last = (mem_addr == last_addr);

endmodule

`default_nettype wire

// File: verilog/sample_path.sv
`default_nettype none

module sample_path (
	input  wire                        clk2,
	input  wire                        pb_reset,
	input  wire  recorder_pkg::sample_t sample_in,
	input  wire                        sample_in_valid,
	input  wire  recorder_pkg::sample_t mem_rdata,
	input  wire                        rd_capture,
	input  wire                        wr_zero,
	input  wire  [3:0]                 volume,
	output recorder_pkg::sample_t      mem_wdata,
	output recorder_pkg::sample_t      audio_out
);
	import recorder_pkg::*;

	sample_t                    rec_sample;
	sample_t                    play_sample;
	logic signed [SAMPLE_W+4:0] scaled;

	// incoming sample and the last word read back
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			rec_sample  <= '0;
			play_sample <= '0;
		end else begin
			if (sample_in_valid) begin
				rec_sample <= sample_in;
			end
			if (rd_capture) begin
				play_sample <= mem_rdata;
			end
		end
	end

	// erase writes zeros
	assign mem_wdata = wr_zero ? '0 : rec_sample;

	//////////////////////////////////////////////////////////////////////
	// volume scaling
	//////////////////////////////////////////////////////////////////////

	// volume is unsigned, zero bit keeps the product signed correctly
	assign scaled = play_sample * $signed({1'b0, volume});

	// divide by 16, full scale at volume 16
	assign audio_out = scaled[SAMPLE_W+3:4];

endmodule

`default_nettype wire

// File: verilog/recorder_top.sv
`default_nettype none

module recorder_top #(
	parameter int ADDR_W     = 12,
	parameter int SLOT_WORDS = 16
) (
	input  wire                         clk2,
	input  wire                         pb_reset,
	// host port bus
	input  wire  [7:0]                  port_id,
	input  wire  [7:0]                  out_port,
	input  wire                         write_strobe,
	input  wire                         read_strobe,
	output logic [7:0]                  in_port,
	// audio in and out
	input  wire  recorder_pkg::sample_t sample_in,
	input  wire                         sample_in_valid,
	output recorder_pkg::sample_t       audio_out,
	output logic                        audio_out_valid,
	// sample memory
	output logic [ADDR_W-1:0]           mem_addr,
	output recorder_pkg::sample_t       mem_wdata,
	output logic                        mem_write,
	output logic                        mem_read_req,
	input  wire  recorder_pkg::sample_t mem_rdata,
	input  wire                         mem_rdata_valid,
	input  wire                         mem_ready
);
	import recorder_pkg::*;

	mode_e      mode;
	logic [2:0] slot;
	logic [3:0] volume;
	logic       record_arm;
	logic       cmd_start;
	logic       cmd_abort;
	logic       addr_load;
	logic       addr_load_all;
	logic       addr_step;
	logic       addr_last;
	logic       rd_capture;
	logic       wr_zero;
	logic       rec_wrote;
	logic       erase_done_pulse;
	logic       erase_all;

	//////////////////////////////////////////////////////////////////////
	// host registers
	//////////////////////////////////////////////////////////////////////

	port_regs i_port_regs (
		.clk2             (clk2),
		.pb_reset         (pb_reset),
		.port_id          (port_id),
		.out_port         (out_port),
		.write_strobe     (write_strobe),
		.read_strobe      (read_strobe),
		.rec_wrote        (rec_wrote),
		.erase_done_pulse (erase_done_pulse),
		.erase_all        (erase_all),
		// flags follow the slot that was last picked
		.cur_slot         (slot),
		.in_port          (in_port),
		.mode             (mode),
		.slot             (slot),
		.record_arm       (record_arm),
		.volume           (volume),
		.cmd_start        (cmd_start),
		.cmd_abort        (cmd_abort)
	);

	// transfer sequencer
	recorder_fsm i_recorder_fsm (
		.clk2             (clk2),
		.pb_reset         (pb_reset),
		.mode             (mode),
		.cmd_start        (cmd_start),
		.cmd_abort        (cmd_abort),
		.record_arm       (record_arm),
		.sample_in_valid  (sample_in_valid),
		.mem_ready        (mem_ready),
		.mem_rdata_valid  (mem_rdata_valid),
		.addr_last        (addr_last),
		.state            (),
		.addr_load        (addr_load),
		.addr_load_all    (addr_load_all),
		.addr_step        (addr_step),
		.mem_read_req     (mem_read_req),
		.mem_write        (mem_write),
		.rd_capture       (rd_capture),
		.wr_zero          (wr_zero),
		.audio_out_valid  (audio_out_valid),
		.rec_wrote        (rec_wrote),
		.erase_done_pulse (erase_done_pulse),
		.erase_all        (erase_all)
	);

	// memory address ranges
	address_counter #(
		.ADDR_W     (ADDR_W),
		.SLOT_WORDS (SLOT_WORDS)
	) i_address_counter (
		.clk2          (clk2),
		.pb_reset      (pb_reset),
		.slot          (slot),
		.addr_load     (addr_load),
		.addr_load_all (addr_load_all),
		.addr_step     (addr_step),
		.mem_addr      (mem_addr),
		.addr_last     (addr_last)
	);

	// write data and playback scaling
	sample_path i_sample_path (
		.clk2            (clk2),
		.pb_reset        (pb_reset),
		.sample_in       (sample_in),
		.sample_in_valid (sample_in_valid),
		.mem_rdata       (mem_rdata),
		.rd_capture      (rd_capture),
		.wr_zero         (wr_zero),
		.volume          (volume),
		.mem_wdata       (mem_wdata),
		.audio_out       (audio_out)
	);

endmodule

`default_nettype wire

// File: dv/sample_mem_model.sv
`default_nettype none

module sample_mem_model #(
	parameter int ADDR_W = 12
) (
	input  wire                         clk2,
	input  wire                         pb_reset,
	input  wire  [ADDR_W-1:0]           mem_addr,
	input  wire  recorder_pkg::sample_t mem_wdata,
	input  wire                         mem_write,
	input  wire                         mem_read_req,
	output recorder_pkg::sample_t       mem_rdata,
	output logic                        mem_rdata_valid,
	output logic                        mem_ready
);
	import recorder_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	sample_t           mem [0:DEPTH-1];
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_busy;
	logic [1:0]        rd_wait;

	// power-up contents, every word different
	initial begin
		for (int a = 0; a < DEPTH; a++) begin
			mem[a] = 16'(a * 40503 + 12345);
		end
	end

	always @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			mem_ready       <= 1'b0;
			mem_rdata       <= '0;
			mem_rdata_valid <= 1'b0;
			rd_addr         <= '0;
			rd_busy         <= 1'b0;
			rd_wait         <= 2'd0;
		end else begin
			// ready drops about one cycle in four
			mem_ready       <= ($urandom % 4) != 0;
			mem_rdata_valid <= 1'b0;
			if (mem_write) begin
				mem[mem_addr] <= mem_wdata;
			end
			// read answers 1 to 4 edges after the request
			if (mem_read_req && mem_ready) begin
				rd_busy <= 1'b1;
				rd_addr <= mem_addr;
				rd_wait <= 2'($urandom % 4);
			end else if (rd_busy) begin
				if (rd_wait == 2'd0) begin
					mem_rdata       <= mem[rd_addr];
					mem_rdata_valid <= 1'b1;
					rd_busy         <= 1'b0;
				end else begin
					rd_wait <= rd_wait - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/recorder_chk.sv
`default_nettype none

module recorder_chk (
	input  wire                         clk2,
	input  wire                         pb_reset,
	input  wire  recorder_pkg::state_e  state,
	input  wire                         mem_read_req,
	input  wire                         mem_write,
	input  wire                         mem_rdata_valid
);
	import recorder_pkg::*;

	logic read_open;

	// open from the request edge until the data comes back
	always @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			read_open <= 1'b0;
		end else if (mem_read_req) begin
			read_open <= 1'b1;
		end else if (mem_rdata_valid) begin
			read_open <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory handshake
	//////////////////////////////////////////////////////////////////////

	// never a read and a write in the same cycle
	a_no_read_with_write: assert property (@(posedge clk2) disable iff (pb_reset)
		!(mem_read_req && mem_write))
		else $error("memory read and write requested in the same cycle");

	// one read in flight, fsm parked in the wait state until its data
	a_single_read: assert property (@(posedge clk2) disable iff (pb_reset)
		read_open |-> (!mem_read_req && (state == ST_PLAY_WAIT)))
		else $error("memory read issued or wait left while another read is still open");

endmodule

bind recorder_fsm recorder_chk i_recorder_chk (
	.clk2            (clk2),
	.pb_reset        (pb_reset),
	.state           (state),
	.mem_read_req    (mem_read_req),
	.mem_write       (mem_write),
	.mem_rdata_valid (mem_rdata_valid)
);

`default_nettype wire

// File: dv/recorder_tb.sv
`default_nettype none

module recorder_tb;
	import recorder_pkg::*;

	localparam int ADDR_W     = 12;
	localparam int SLOT_WORDS = 16;
	localparam int AREA_WORDS = NUM_SLOTS * SLOT_WORDS;
	localparam int DRIVE_DLY  = 2;
	localparam int WAIT_MAX   = 64;

	logic              clk2;
	logic              pb_reset;
	logic [7:0]        port_id;
	logic [7:0]        out_port;
	logic              write_strobe;
	logic              read_strobe;
	logic [7:0]        in_port;
	sample_t           sample_in;
	logic              sample_in_valid;
	sample_t           audio_out;
	logic              audio_out_valid;
	logic [ADDR_W-1:0] mem_addr;
	sample_t           mem_wdata;
	logic              mem_write;
	logic              mem_read_req;
	sample_t           mem_rdata;
	logic              mem_rdata_valid;
	logic              mem_ready;

	// expected state, kept from the port rules
	string      test_name;
	int         write_count = 0;
	logic [3:0] exp_vol;
	logic [4:0] exp_occ;
	logic       exp_done;
	sample_t    shadow [0:AREA_WORDS-1];

	recorder_top #(
		.ADDR_W     (ADDR_W),
		.SLOT_WORDS (SLOT_WORDS)
	) i_recorder_top (
		.clk2            (clk2),
		.pb_reset        (pb_reset),
		.port_id         (port_id),
		.out_port        (out_port),
		.write_strobe    (write_strobe),
		.read_strobe     (read_strobe),
		.in_port         (in_port),
		.sample_in       (sample_in),
		.sample_in_valid (sample_in_valid),
		.audio_out       (audio_out),
		.audio_out_valid (audio_out_valid),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_write       (mem_write),
		.mem_read_req    (mem_read_req),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid),
		.mem_ready       (mem_ready)
	);

	sample_mem_model #(
		.ADDR_W (ADDR_W)
	) sample_mem (
		.clk2            (clk2),
		.pb_reset        (pb_reset),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_write       (mem_write),
		.mem_read_req    (mem_read_req),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid),
		.mem_ready       (mem_ready)
	);

	always #20 clk2 = ~clk2;

	// writes accepted by the memory
	always @(posedge clk2) begin
		if (mem_write && mem_ready) begin
			write_count <= write_count + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checking and failure
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "first error in %s", test_name);
	endtask

	task automatic check_eq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
			stop_run();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout in %s: %s did not happen in time", test_name, what);
		stop_run();
	endtask

	// volume scale, product over 16 rounded toward minus infinity
	function automatic sample_t scale_sample(input sample_t s, input logic [3:0] vol);
		int p;
		p = int'(s) * int'(vol);
		return 16'(p >>> 4);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// host bus and audio drivers
	//////////////////////////////////////////////////////////////////////

	task automatic port_write(input logic [7:0] id, input logic [7:0] data);
		@(posedge clk2);
		#DRIVE_DLY;
		port_id      = id;
		out_port     = data;
		write_strobe = 1'b1;
		@(posedge clk2);
		#DRIVE_DLY;
		write_strobe = 1'b0;
	endtask

	// in_port holds the value from the strobe edge on
	task automatic port_read(input logic [7:0] id, output logic [7:0] data);
		@(posedge clk2);
		#DRIVE_DLY;
		port_id     = id;
		read_strobe = 1'b1;
		@(posedge clk2);
		#DRIVE_DLY;
		read_strobe = 1'b0;
		data        = in_port;
	endtask

	task automatic send_sample(input sample_t s);
		@(posedge clk2);
		#DRIVE_DLY;
		sample_in       = s;
		sample_in_valid = 1'b1;
		@(posedge clk2);
		#DRIVE_DLY;
		sample_in_valid = 1'b0;
	endtask

	// returns in the cycle before the write edge
	task automatic wait_mem_write(input string what);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < WAIT_MAX && !seen; i++) begin
			@(negedge clk2);
			seen = mem_write;
		end
		if (!seen) begin
			report_timeout(what);
		end
	endtask

	task automatic wait_erase_done();
		logic [7:0] st;
		bit         done;
		done = 1'b0;
		for (int i = 0; i < WAIT_MAX * 4 && !done; i++) begin
			port_read(PORT_STATUS, st);
			done = st[0];
		end
		if (!done) begin
			report_timeout("erase done flag");
		end
		exp_done = 1'b1;
	endtask

	task automatic check_status();
		logic [7:0] st;
		port_read(PORT_STATUS, st);
		check_eq("status byte", {2'b00, exp_occ, exp_done}, st);
	endtask

	task automatic compare_area();
		for (int a = 0; a < AREA_WORDS; a++) begin
			check_eq($sformatf("mem[%0d]", a), shadow[a], sample_mem.mem[a]);
		end
	endtask

	// arm, pick the slot and feed random samples
	task automatic record_slot(input int slot, input int words);
		sample_t s;
		port_write(PORT_MODE, MODE_RECORD);
		port_write(PORT_RECORD, 8'h01);
		port_write(PORT_SLOT, 8'(slot));
		exp_done = 1'b0;
		for (int i = 0; i < words; i++) begin
			s = 16'($urandom);
			send_sample(s);
			wait_mem_write($sformatf("write of word %0d", i));
			shadow[slot * SLOT_WORDS + i] = s;
		end
		exp_occ[slot] = 1'b1;
	endtask

	task automatic play_slot(input int slot);
		bit seen;
		port_write(PORT_MODE, MODE_PLAY);
		port_write(PORT_SLOT, 8'(slot));
		exp_done = 1'b0;
		for (int i = 0; i < SLOT_WORDS; i++) begin
			seen = 1'b0;
			for (int t = 0; t < WAIT_MAX && !seen; t++) begin
				@(negedge clk2);
				seen = audio_out_valid;
			end
			if (!seen) begin
				report_timeout($sformatf("audio word %0d", i));
			end
			check_eq($sformatf("audio word %0d", i),
				scale_sample(shadow[slot * SLOT_WORDS + i], exp_vol), audio_out);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_volume();
		logic [7:0] v;
		test_name = "volume";
		port_read(PORT_VOL_LEVEL, v);
		check_eq("level after reset", 8, v);
		port_write(PORT_MODE, MODE_VOL);
		repeat (10) port_write(PORT_VOLUME, 8'd1);
		port_read(PORT_VOL_LEVEL, v);
		check_eq("level after up steps", 15, v);
		repeat (20) port_write(PORT_VOLUME, 8'd2);
		port_read(PORT_VOL_LEVEL, v);
		check_eq("level after down steps", 1, v);
		exp_vol = 4'd1;
	endtask

	task automatic test_record_play();
		logic [7:0] v;
		test_name = "record and play";
		// louder playback, still in volume mode
		repeat (9) port_write(PORT_VOLUME, 8'd1);
		exp_vol = 4'd10;
		port_read(PORT_VOL_LEVEL, v);
		check_eq("playback level", exp_vol, v);
		record_slot(2, SLOT_WORDS);
		check_status();
		compare_area();
		play_slot(2);
	endtask

	task automatic test_delete_one();
		test_name = "delete one";
		record_slot(1, SLOT_WORDS);
		record_slot(3, SLOT_WORDS);
		check_status();
		port_write(PORT_MODE, MODE_DELONE);
		port_write(PORT_SLOT, 8'd1);
		exp_done = 1'b0;
		wait_erase_done();
		for (int i = 0; i < SLOT_WORDS; i++) begin
			shadow[SLOT_WORDS + i] = '0;
		end
		exp_occ[1] = 1'b0;
		check_status();
		compare_area();
		// erased slot plays back silence
		play_slot(1);
	endtask

	task automatic test_delete_all();
		test_name = "delete all";
		port_write(PORT_MODE, MODE_DELALL);
		exp_done = 1'b0;
		wait_erase_done();
		for (int a = 0; a < AREA_WORDS; a++) begin
			shadow[a] = '0;
		end
		exp_occ = '0;
		compare_area();
		check_status();
	endtask

	task automatic test_abort();
		int writes_before;
		test_name = "abort";
		record_slot(0, 6);
		// mode write cuts the recording short
		port_write(PORT_MODE, MODE_MAIN);
		writes_before = write_count;
		repeat (4) send_sample(16'($urandom));
		repeat (8) @(posedge clk2);
		check_eq("writes after abort", writes_before, write_count);
		compare_area();
		check_status();
	endtask

	initial begin
		clk2            = 1'b0;
		pb_reset        = 1'b1;
		port_id         = 8'h00;
		out_port        = 8'h00;
		write_strobe    = 1'b0;
		read_strobe     = 1'b0;
		sample_in       = '0;
		sample_in_valid = 1'b0;
		exp_vol         = VOL_RESET;
		exp_occ         = '0;
		exp_done        = 1'b0;
		test_name       = "reset";
		void'($urandom(32'h18fc));
		repeat (16) @(posedge clk2);
		#DRIVE_DLY;
		pb_reset = 1'b0;
		// memory image before any transfer
		for (int a = 0; a < AREA_WORDS; a++) begin
			shadow[a] = sample_mem.mem[a];
		end
		check_status();
		test_volume();
		test_record_play();
		test_delete_one();
		test_delete_all();
		test_abort();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
verilog/recorder_pkg.sv
verilog/port_regs.sv
verilog/recorder_fsm.sv
verilog/address_counter.sv
verilog/sample_path.sv
verilog/recorder_top.sv
dv/sample_mem_model.sv
dv/recorder_chk.sv
dv/recorder_tb.sv

// File: run.sh
#!/bin/sh
# build the recorder testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module recorder_tb \
	-f project.f -o recorder_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/recorder_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
